/* common/z80_bus_pkg.sv */
// shared definitions for the CPU side of the I/O bridge
// the decoder, the write CDC, the register bank and the top level import this
// package for the bus vector types and the location of the port window

package z80_bus_pkg;

    // ********************
    // bus vector types
    // ********************

    // an I/O port address as seen on the low byte of the address bus
    typedef logic [7:0] addr_t;

    // one byte on the data bus, also the width of each output port
    typedef logic [7:0] data_t;

    // count of accepted writes
    // it wraps from 255 back to 0 with no overflow flag
    typedef logic [7:0] count_t;

    // ********************
    // port window
    // ********************

    // first port of the window
    // the window spans IO_BASE up to IO_BASE+3 so the low two bits must be zero
    localparam addr_t IO_BASE = 8'h40;

    // number of output ports behind the window
    // the decoder compares the address bits above the port select against IO_BASE
    // and the bank uses the bits below as the port index
    localparam int NUM_PORTS = 4;

endpackage

/* common/cdc_pkg.sv */
// sizes of the clock crossing and the decoder state encoding
// imported by the decoder and by the pulse stretcher and synchronizer

package cdc_pkg;

    // length of the stretched tick in clk1 cycles
    localparam int STRETCH_CYCLES = 2;

    // number of synchronizer flops in the clk2 domain, two or more
    localparam int SYNC_LEN = 2;

    // counter that times the stretched pulse, wide enough to hold STRETCH_CYCLES
    typedef logic [$clog2(STRETCH_CYCLES + 1) - 1:0] stretch_cnt_t;

    // states of the bus cycle decoder
    // T1 is the first qualified sample and TICK the cycle that issues wr_tick1
    typedef enum logic [1:0] {
        IDLE,
        T1,
        TICK,
        WAIT_END
    } decode_state_t;

endpackage

/* cdc/sync_stretch.sv */
// carries a one-cycle tick from the clk1 domain into the clk2 domain
// the tick is stretched in clk1 so that a faster clk2 cannot miss it and is then
// resynchronized and edge detected into a single clk2 cycle
// ticks must be spaced far enough apart for each stretch to pass through the chain

`timescale 1ns/1ps

module sync_stretch
    import cdc_pkg::*;
(
    input  logic clk1,
    input  logic clk2,
    input  logic rst_n,
    input  logic pulse_in,
    output logic pulse_out
);

    // ********************
    // clk1 side
    // ********************

    stretch_cnt_t cnt_q;
    logic         stretch_q;

    // the stretched level comes straight from a flop
    // so no combinational glitch can reach the synchronizer
    always_ff @(posedge clk1 or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q     <= '0;
            stretch_q <= 1'b0;
        end else if (pulse_in) begin
            // the cycle in which the level rises counts as the first one
            cnt_q     <= stretch_cnt_t'(STRETCH_CYCLES - 1);
            stretch_q <= 1'b1;
        end else if (cnt_q != '0) begin
            cnt_q     <= cnt_q - 1'b1;
            stretch_q <= 1'b1;
        end else begin
            stretch_q <= 1'b0;
        end
    end

    // ********************
    // clk2 side
    // ********************

    logic [SYNC_LEN-1:0] sync_q;
    logic                last_q;

    // the first flop may go metastable and the rest of the chain lets it settle
    always_ff @(posedge clk2 or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
            last_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[SYNC_LEN-2:0], stretch_q};
            last_q <= sync_q[SYNC_LEN-1];
        end
    end

    // rising edge of the synchronized level gives one clk2 cycle per stretched pulse
    assign pulse_out = sync_q[SYNC_LEN-1] & ~last_q;

endmodule

/* cdc/z80_wr_cdc.sv */
// moves a CPU write from the clk1 domain into the clk2 domain
// address and data are captured in clk1 on wr_tick1 and held while the tick
// crosses, so the clk2 side sees stable values when wr_tick2 arrives
// the next wr_tick1 must not come before the previous wr_tick2

`timescale 1ns/1ps

module z80_wr_cdc
    import z80_bus_pkg::*;
(
    // clk1 is normally the CPU phi clock
    input  logic  clk1,
    // clk2 clocks the peripheral side
    input  logic  clk2,
    input  logic  rst_n,
    input  logic  wr_tick1,
    input  addr_t addr1,
    input  data_t data1,
    output logic  wr_tick2,
    output addr_t aout2,
    output data_t dout2
);

    // ********************
    // capture register
    // ********************

    // the values load one clk1 cycle after the tick and then stay put
    // clk2 reads them only once the tick has come through the synchronizer,
    // which is several clk2 cycles after they last changed
    always_ff @(posedge clk1) begin
        if (wr_tick1) begin
            aout2 <= addr1;
            dout2 <= data1;
        end
    end

    // ********************
    // tick crossing
    // ********************

    // the stretcher starts on the same clk1 edge that loads the capture register,
    // so wr_tick2 always trails the data by at least the synchronizer depth
    sync_stretch u_stretch (
        .clk1      (clk1),
        .clk2      (clk2),
        .rst_n     (rst_n),
        .pulse_in  (wr_tick1),
        .pulse_out (wr_tick2)
    );

endmodule

/* hdl/z80_io_decode.sv */
// bus cycle decoder for CPU I/O writes into the four-port window
// it samples the bus on rising clk1 edges and raises wr_tick1 for one cycle per
// qualified write cycle, registering address and data alongside the tick
// iorq_n has to be seen high again before another tick can follow

`timescale 1ns/1ps

module z80_io_decode
    import z80_bus_pkg::*;
    import cdc_pkg::*;
(
    input  logic  clk1,
    input  logic  rst_n,
    input  logic  iorq_n,
    input  logic  wr_n,
    input  addr_t addr,
    input  data_t din,
    output logic  wr_tick1,
    output addr_t addr1,
    output data_t data1
);

    decode_state_t state_q;
    decode_state_t state_d;
    logic          in_window;
    logic          io_wr;

    // ********************
    // bus qualification
    // ********************

    // only the bits above the port select have to match the window base
    assign in_window = addr[$bits(addr_t)-1:$clog2(NUM_PORTS)] ==
                       IO_BASE[$bits(addr_t)-1:$clog2(NUM_PORTS)];

    // an I/O write into the window, as seen on one clk1 edge
    assign io_wr = !iorq_n && !wr_n && in_window;

    // ********************
    // state machine
    // ********************

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // a cycle that does not qualify yet is simply sampled again
                if (io_wr) begin
                    state_d = T1;
                end
            end
            T1: begin
                if (io_wr) begin
                    state_d = TICK;
                end else if (iorq_n) begin
                    state_d = IDLE;
                end else begin
                    // the cycle lost its write strobe so it is ignored to its end
                    state_d = WAIT_END;
                end
            end
            // two samples agreed and the tick goes out on this edge
            TICK: state_d = WAIT_END;
            WAIT_END: begin
                if (iorq_n) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk1 or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            wr_tick1 <= 1'b0;
        end else begin
            state_q  <= state_d;
            // TICK lasts one cycle so the registered tick does too
            wr_tick1 <= state_q == TICK;
        end
    end

    // address and data are taken from the bus on the same edge that raises the tick
    always_ff @(posedge clk1) begin
        if (state_q == TICK) begin
            addr1 <= addr;
            data1 <= din;
        end
    end

endmodule

/* hdl/io_reg_bank.sv */
// register bank in the clk2 domain behind the I/O bridge
// each wr_tick2 writes the crossed data byte into one of four output ports
// and bumps a wrapping count of accepted writes
// the address was already checked against the window in the clk1 domain

`timescale 1ns/1ps

module io_reg_bank
    import z80_bus_pkg::*;
(
    input  logic   clk2,
    input  logic   rst_n,
    input  logic   wr_tick2,
    input  addr_t  aout2,
    input  data_t  dout2,
    output data_t  port_a,
    output data_t  port_b,
    output data_t  port_c,
    output data_t  port_d,
    output count_t wr_count
);

    data_t                port_q [NUM_PORTS];
    logic [NUM_PORTS-1:0] port_we;

    // ********************
    // write decode
    // ********************

    // the low address bits pick the port
    // aout2 is settled long before the tick, so this select is quiet when it is used
    always_comb begin
        port_we = '0;
        if (wr_tick2) begin
            port_we[aout2[$clog2(NUM_PORTS)-1:0]] = 1'b1;
        end
    end

    // ********************
    // port registers
    // ********************

    // the ports are visible CPU state and must read zero after reset
    always_ff @(posedge clk2 or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                port_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (port_we[i]) begin
                    port_q[i] <= dout2;
                end
            end
        end
    end

    // port order follows the address, port_a sits at IO_BASE
    assign port_a = port_q[0];
    assign port_b = port_q[1];
    assign port_c = port_q[2];
    assign port_d = port_q[3];

    // ********************
    // write counter
    // ********************

    // one count per crossed tick, so a change here marks the end of a write
    // the counter rolls over silently at 255
    always_ff @(posedge clk2 or negedge rst_n) begin
        if (!rst_n) begin
            wr_count <= '0;
        end else if (wr_tick2) begin
            wr_count <= wr_count + 1'b1;
        end
    end

endmodule

/* hdl/z80_io_bridge.sv */
// top level of the write-only I/O bridge
// the CPU bus runs on clk1 and the output ports on clk2
// a write passes through the decoder, then the write CDC, then the register bank
// bus cycles must leave enough idle time for each write to cross before the next

`timescale 1ns/1ps

module z80_io_bridge
    import z80_bus_pkg::*;
(
    input  logic   clk1,
    input  logic   clk2,
    input  logic   rst_n,
    input  logic   iorq_n,
    input  logic   wr_n,
    input  addr_t  addr,
    input  data_t  din,
    output data_t  port_a,
    output data_t  port_b,
    output data_t  port_c,
    output data_t  port_d,
    output count_t wr_count
);

    // clk1 domain write from the decoder
    logic  wr_tick1;
    addr_t addr1;
    data_t data1;

    // clk2 domain write from the crossing
    logic  wr_tick2;
    addr_t aout2;
    data_t dout2;

    z80_io_decode u_decode (
        .clk1     (clk1),
        .rst_n    (rst_n),
        .iorq_n   (iorq_n),
        .wr_n     (wr_n),
        .addr     (addr),
        .din      (din),
        .wr_tick1 (wr_tick1),
        .addr1    (addr1),
        .data1    (data1)
    );

    z80_wr_cdc u_wr_cdc (
        .clk1     (clk1),
        .clk2     (clk2),
        .rst_n    (rst_n),
        .wr_tick1 (wr_tick1),
        .addr1    (addr1),
        .data1    (data1),
        .wr_tick2 (wr_tick2),
        .aout2    (aout2),
        .dout2    (dout2)
    );

    io_reg_bank u_bank (
        .clk2     (clk2),
        .rst_n    (rst_n),
        .wr_tick2 (wr_tick2),
        .aout2    (aout2),
        .dout2    (dout2),
        .port_a   (port_a),
        .port_b   (port_b),
        .port_c   (port_c),
        .port_d   (port_d),
        .wr_count (wr_count)
    );

endmodule

/* tb/z80_io_bridge_assert.sv */
// concurrent checks on the write ticks inside the I/O bridge
// bound into every z80_io_bridge instance by the bind statement at the end of this file

`timescale 1ns/1ps

module z80_io_bridge_assert
    import z80_bus_pkg::*;
(
    input logic  clk1,
    input logic  clk2,
    input logic  rst_n,
    input logic  wr_tick1,
    input logic  wr_tick2,
    input addr_t aout2,
    input data_t dout2
);

    // number of assertion violations seen so far
    int fail_count = 0;

    // ********************
    // tick width
    // ********************

    // one bus cycle gives exactly one clk1 tick
    tick1_single: assert property (
        @(posedge clk1) disable iff (!rst_n) wr_tick1 |=> !wr_tick1
    ) else begin
        $error("wr_tick1 stayed high for two clk1 cycles");
        fail_count++;
    end

    // the edge detector after the synchronizer allows one clk2 cycle only
    tick2_single: assert property (
        @(posedge clk2) disable iff (!rst_n) wr_tick2 |=> !wr_tick2
    ) else begin
        $error("wr_tick2 stayed high for two clk2 cycles");
        fail_count++;
    end

    // ********************
    // crossed data
    // ********************

    // the captured address and data must already be settled when the bank uses them
    crossed_stable: assert property (
        @(posedge clk2) disable iff (!rst_n) wr_tick2 |-> $stable(aout2) && $stable(dout2)
    ) else begin
        $error("aout2 or dout2 changed in the cycle of wr_tick2");
        fail_count++;
    end

endmodule

bind z80_io_bridge z80_io_bridge_assert u_assert (
    .clk1     (clk1),
    .clk2     (clk2),
    .rst_n    (rst_n),
    .wr_tick1 (wr_tick1),
    .wr_tick2 (wr_tick2),
    .aout2    (aout2),
    .dout2    (dout2)
);

/* tb/tb_z80_io_bridge.sv */
// testbench for the write-only I/O bridge
// drives CPU I/O bus cycles on clk1 and watches the output ports on clk2
// a small model of four ports and a write counter predicts every result
// random addresses, data and cycle lengths come from an LCG with a fixed seed

`timescale 1ns/1ps

module tb_z80_io_bridge
    import z80_bus_pkg::*;
();

    logic   clk1;
    logic   clk2;
    logic   rst_n;
    logic   iorq_n;
    logic   wr_n;
    addr_t  addr;
    data_t  din;
    data_t  port_a;
    data_t  port_b;
    data_t  port_c;
    data_t  port_d;
    count_t wr_count;

    // model state and bookkeeping
    data_t       model_port [NUM_PORTS];
    count_t      model_count;
    int          writes_total;
    int          errors;
    int          checks;
    int          tests;
    int          errors_at_start;
    logic [31:0] lcg_state;

    z80_io_bridge u_dut (
        .clk1     (clk1),
        .clk2     (clk2),
        .rst_n    (rst_n),
        .iorq_n   (iorq_n),
        .wr_n     (wr_n),
        .addr     (addr),
        .din      (din),
        .port_a   (port_a),
        .port_b   (port_b),
        .port_c   (port_c),
        .port_d   (port_d),
        .wr_count (wr_count)
    );

    // ********************
    // clocks
    // ********************

    // clk1 rises at 10+20k and clk2 at 7+14k, so their rising edges never meet
    initial begin
        clk1 = 1'b0;
        forever #10 clk1 = ~clk1;
    end

    initial begin
        clk2 = 1'b0;
        forever #7 clk2 = ~clk2;
    end

    // ********************
    // helpers
    // ********************

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // the window is IO_BASE to IO_BASE+3, so only the top six bits are compared
    function automatic logic in_window(addr_t a);
        return (a & 8'hfc) == (IO_BASE & 8'hfc);
    endfunction

    task automatic check_value(string name, logic [7:0] expected, logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected %02h actual %02h", name, expected, actual);
        end
    endtask

    task automatic check_all(string name);
        check_value({name, " port_a"}, model_port[0], port_a);
        check_value({name, " port_b"}, model_port[1], port_b);
        check_value({name, " port_c"}, model_port[2], port_c);
        check_value({name, " port_d"}, model_port[3], port_d);
        check_value({name, " wr_count"}, model_count, wr_count);
    endtask

    task automatic end_test(string name);
        tests++;
        $display("test %s finished with %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    task automatic idle(int n);
        repeat (n) @(posedge clk1);
    endtask

    // one I/O cycle that holds the bus low for low_cycles clk1 edges and then releases it
    task automatic bus_cycle(addr_t a, data_t d, logic is_write, int low_cycles);
        @(posedge clk1);
        #2;
        addr   = a;
        din    = d;
        iorq_n = 1'b0;
        wr_n   = !is_write;
        repeat (low_cycles) @(posedge clk1);
        #2;
        iorq_n = 1'b1;
        wr_n   = 1'b1;
    endtask

    // the counter moves once the write has reached the bank
    task automatic wait_count_change(count_t old);
        int cycles;
        cycles = 0;
        @(negedge clk1);
        while (wr_count == old && cycles < 40) begin
            cycles++;
            @(negedge clk1);
        end
        if (wr_count == old) begin
            errors++;
            $display("timeout: wr_count did not change within 40 clk1 cycles of a write");
        end
    endtask

    // an in-window write that is checked when it lands and again after the idle gap
    task automatic do_write(string name, addr_t a, data_t d, int low_cycles);
        count_t old;
        old = wr_count;
        bus_cycle(a, d, 1'b1, low_cycles);
        model_port[a[1:0]] = d;
        model_count++;
        writes_total++;
        wait_count_change(old);
        check_all(name);
        // the gap also shows whether a long cycle gave a second tick
        idle(6);
        @(negedge clk1);
        check_all({name, " after gap"});
    endtask

    // a cycle that must leave every output alone
    task automatic do_ignored(string name, addr_t a, data_t d, logic is_write);
        bus_cycle(a, d, is_write, 4);
        idle(20);
        @(negedge clk1);
        check_all(name);
    endtask

    task automatic apply_reset();
        @(posedge clk1);
        #2;
        rst_n = 1'b0;
        repeat (8) @(posedge clk1);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_PORTS; i++) begin
            model_port[i] = '0;
        end
        model_count  = '0;
        writes_total = 0;
    endtask

    // ********************
    // test sequence
    // ********************

    initial begin
        logic [31:0] r;
        addr_t       a;
        lcg_state       = 32'h40b4d742;
        rst_n           = 1'b0;
        iorq_n          = 1'b1;
        wr_n            = 1'b1;
        addr            = '0;
        din             = '0;
        errors          = 0;
        checks          = 0;
        tests           = 0;
        errors_at_start = 0;
        apply_reset();
        @(negedge clk1);
        check_all("reset values");
        end_test("reset values");

        for (int i = 0; i < NUM_PORTS; i++) begin
            do_write("directed", addr_t'(IO_BASE + i), data_t'(8'h11 * (i + 1)), 4);
        end
        end_test("directed");

        // out-of-window addresses where a draw inside the window gets bit 7 flipped
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            a = r[15:8];
            if (in_window(a)) begin
                a = a ^ 8'h80;
            end
            do_ignored("ignored out of window", a, r[23:16], 1'b1);
        end
        // in-window I/O cycles without the write strobe
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            do_ignored("ignored no strobe", addr_t'(IO_BASE + r[9:8]), r[23:16], 1'b0);
        end
        end_test("ignored cycles");

        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            do_write("random writes", addr_t'(IO_BASE + r[9:8]), r[23:16], 4);
        end
        check_all("random writes end");
        check_value("random writes total", count_t'(writes_total % 256), wr_count);
        end_test("random writes");

        // iorq_n is held low for 4 to 11 cycles and each cycle must still count once
        for (int i = 0; i < 60; i++) begin
            r = next_rand();
            do_write("long iorq", addr_t'(IO_BASE + r[9:8]), r[23:16], 4 + r[27:25]);
        end
        check_value("long iorq total", count_t'(writes_total % 256), wr_count);
        end_test("long iorq");

        apply_reset();
        @(negedge clk1);
        check_all("mid-run reset");
        for (int i = 0; i < NUM_PORTS; i++) begin
            do_write("after reset", addr_t'(IO_BASE + i), data_t'(8'h5a ^ (i * 8'h24)), 4);
        end
        end_test("mid-run reset");

        if (u_dut.u_assert.fail_count != 0) begin
            errors++;
            $display("bound assertions failed %0d times", u_dut.u_assert.fail_count);
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* z80_io_bridge.f */
common/z80_bus_pkg.sv
common/cdc_pkg.sv
cdc/sync_stretch.sv
cdc/z80_wr_cdc.sv
hdl/z80_io_decode.sv
hdl/io_reg_bank.sv
hdl/z80_io_bridge.sv
tb/z80_io_bridge_assert.sv
tb/tb_z80_io_bridge.sv
